//--- source/serial_bus_pkg.sv
// shared header layout, word and address types of the serial slave, referenced by scoped name
package serial_bus_pkg;

    // serial word and header field widths
    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 8;
    localparam int ID_WIDTH    = 2;
    localparam int START_WIDTH = 3;

    // every valid header opens with this pattern
    localparam logic [START_WIDTH-1:0] START_CODE = 3'b111;

    // start + target id + write + burst + address
    localparam int HEADER_BITS = START_WIDTH + ID_WIDTH + 1 + 1 + ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // first bit seen on control ends up in the top of start
    typedef struct packed {
        logic [START_WIDTH-1:0] start;
        logic [ID_WIDTH-1:0]    target_id;
        logic                   write;
        logic                   burst;
        addr_t                  addr;
    } header_t;

endpackage

//--- source/mem_port_if.sv
// word port between the transfer controller and the slave memory, one modport per side
`timescale 1ns/1ps

interface mem_port_if (
    input logic clk
);

    // write strobe, taken on the clock edge
    logic                  we;
    // read strobe, rdata follows one cycle later
    logic                  re;
    serial_bus_pkg::addr_t addr;
    serial_bus_pkg::word_t wdata;
    serial_bus_pkg::word_t rdata;

    modport controller (
        output we,
        output re,
        output addr,
        output wdata,
        input  rdata
    );

    modport memory (
        input  clk,
        input  we,
        input  re,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- source/serial_deserializer.sv
// msb-first shift-in register, instantiated once for the header and once for write words
`timescale 1ns/1ps

module serial_deserializer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     bit_in,
    input  logic     shift,
    input  logic     clear,
    output payload_t payload,
    output logic     full
);

    localparam int BITS  = $bits(payload_t);
    localparam int CNT_W = $clog2(BITS + 1);

    logic [BITS-1:0]  data;
    logic [CNT_W-1:0] count;
    logic             take;

    // shifts are ignored once the payload is complete
    assign take = shift && !full && !clear;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            full  <= 1'b0;
        end else if (clear) begin
            count <= '0;
            full  <= 1'b0;
        end else if (take) begin
            count <= count + 1'b1;
            if (count == CNT_W'(BITS - 1)) begin
                full <= 1'b1;
            end
        end
    end

    // new bit enters at the bottom, older bits move up
    always_ff @(posedge clk) begin
        if (take) begin
            data <= {data[BITS-2:0], bit_in};
        end
    end

    assign payload = payload_t'(data);

endmodule

//--- source/word_serializer.sv
// msb-first shift-out register that drives the serial read data line
`timescale 1ns/1ps

module word_serializer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  load,
    input  serial_bus_pkg::word_t word,
    input  logic                  advance,
    output logic                  rd_bit,
    output logic                  done
);

    localparam int CNT_W = $clog2(serial_bus_pkg::DATA_WIDTH);

    serial_bus_pkg::word_t shreg;
    logic [CNT_W-1:0]      count;
    logic                  active;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shreg  <= '0;
            count  <= '0;
            active <= 1'b0;
            done   <= 1'b0;
        end else if (load) begin
            shreg  <= word;
            count  <= '0;
            active <= 1'b1;
            done   <= 1'b0;
        end else if (active && advance) begin
            // current msb was consumed, present the next one
            shreg <= shreg << 1;
            count <= count + 1'b1;
            if (count == CNT_W'(serial_bus_pkg::DATA_WIDTH - 1)) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    // a low advance leaves shreg alone, so rd_bit holds through a stall
    assign rd_bit = shreg[serial_bus_pkg::DATA_WIDTH-1];

endmodule

//--- source/slave_memory.sv
// word-wide synchronous ram behind the memory modport, one write port and one registered read
`timescale 1ns/1ps

module slave_memory #(
    parameter int MEM_DEPTH = 256
) (
    input logic              clk,
    mem_port_if.memory       mem
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    serial_bus_pkg::word_t ram [MEM_DEPTH];
    logic [IDX_W-1:0]      idx;

    // addresses wrap around the configured depth
    assign idx = IDX_W'(mem.addr % MEM_DEPTH);

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[idx] <= mem.wdata;
        end
    end

    // rdata keeps the last fetched word until the next re
    always_ff @(posedge clk) begin
        if (mem.re) begin
            mem.rdata <= ram[idx];
        end
    end

endmodule

//--- source/transfer_controller.sv
// fsm that decodes serial headers, sequences write and read words and steps the memory address
`timescale 1ns/1ps

module transfer_controller #(
    parameter int SLAVE_ID = 1
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    control,
    input  logic                    valid,
    input  logic                    last,
    input  serial_bus_pkg::header_t header,
    input  logic                    header_full,
    input  serial_bus_pkg::word_t   word_in,
    input  logic                    word_full,
    input  logic                    ser_done,
    output logic                    header_shift,
    output logic                    header_clear,
    output logic                    word_shift,
    output logic                    word_clear,
    output logic                    ser_load,
    output serial_bus_pkg::word_t   ser_word,
    output logic                    ready,
    mem_port_if.controller          mem
);

    typedef enum logic [2:0] {
        s_idle,
        s_header,
        s_decode,
        s_write_data,
        s_fetch,
        s_load,
        s_read_data
    } state_t;

    state_t                state;
    serial_bus_pkg::addr_t addr;
    logic                  burst;
    // master flagged the final word of a burst
    logic                  saw_last;
    logic                  hdr_match;
    logic                  word_end;

    assign hdr_match = (header.start == serial_bus_pkg::START_CODE)
                    && (header.target_id == serial_bus_pkg::ID_WIDTH'(SLAVE_ID));

    // transfer stops after this word unless a burst is still running
    assign word_end = !burst || saw_last;

    // first header bit is taken straight from idle
    assign header_shift = (state == s_idle && control)
                       || (state == s_header && !header_full);
    assign header_clear = (state == s_decode);

    assign word_shift = (state == s_write_data) && valid && !word_full;
    assign word_clear = (state == s_decode)
                     || (state == s_write_data && word_full);

    // low while a word is stored or the next read word is on its way
    assign ready = (state == s_idle)
                || (state == s_write_data && !word_full)
                || (state == s_read_data && !ser_done);

    assign mem.we    = (state == s_write_data) && word_full;
    assign mem.re    = (state == s_fetch);
    assign mem.addr  = addr;
    assign mem.wdata = word_in;

    // memory word arrives in the cycle of the load
    assign ser_load = (state == s_load);
    assign ser_word = mem.rdata;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= s_idle;
            addr     <= '0;
            burst    <= 1'b0;
            saw_last <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (control) begin
                        state <= s_header;
                    end
                end

                s_header: begin
                    if (header_full) begin
                        state <= s_decode;
                    end
                end

                s_decode: begin
                    saw_last <= 1'b0;
                    if (hdr_match) begin
                        addr  <= header.addr;
                        burst <= header.burst;
                        state <= header.write ? s_write_data : s_fetch;
                    end else begin
                        // wrong start code or another target, drop it
                        state <= s_idle;
                    end
                end

                s_write_data: begin
                    if (word_full) begin
                        saw_last <= 1'b0;
                        if (word_end) begin
                            state <= s_idle;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end else if (valid && last) begin
                        // ready is high here, so this bit was accepted
                        saw_last <= 1'b1;
                    end
                end

                s_fetch: begin
                    state <= s_load;
                end

                s_load: begin
                    state <= s_read_data;
                end

                s_read_data: begin
                    if (ser_done) begin
                        saw_last <= 1'b0;
                        if (word_end) begin
                            state <= s_idle;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= s_fetch;
                        end
                    end else if (valid && last) begin
                        saw_last <= 1'b1;
                    end
                end

                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

//--- source/serial_slave.sv
// top level of the bit-serial memory target, plain serial pins around controller, shifters and ram
`timescale 1ns/1ps

module serial_slave #(
    parameter int SLAVE_ID  = 1,
    parameter int MEM_DEPTH = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);

    serial_bus_pkg::header_t header;
    logic                    header_shift;
    logic                    header_clear;
    logic                    header_full;
    serial_bus_pkg::word_t   word_in;
    logic                    word_shift;
    logic                    word_clear;
    logic                    word_full;
    logic                    ser_load;
    logic                    ser_done;
    serial_bus_pkg::word_t   ser_word;

    mem_port_if mem_bus (
        .clk(clk)
    );

    transfer_controller #(
        .SLAVE_ID(SLAVE_ID)
    ) i_transfer_controller (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .valid       (valid),
        .last        (last),
        .header      (header),
        .header_full (header_full),
        .word_in     (word_in),
        .word_full   (word_full),
        .ser_done    (ser_done),
        .header_shift(header_shift),
        .header_clear(header_clear),
        .word_shift  (word_shift),
        .word_clear  (word_clear),
        .ser_load    (ser_load),
        .ser_word    (ser_word),
        .ready       (ready),
        .mem         (mem_bus.controller)
    );

    serial_deserializer #(
        .payload_t(serial_bus_pkg::header_t)
    ) i_header_deser (
        .clk    (clk),
        .rstN   (rstN),
        .bit_in (control),
        .shift  (header_shift),
        .clear  (header_clear),
        .payload(header),
        .full   (header_full)
    );

    serial_deserializer #(
        .payload_t(serial_bus_pkg::word_t)
    ) i_word_deser (
        .clk    (clk),
        .rstN   (rstN),
        .bit_in (wd),
        .shift  (word_shift),
        .clear  (word_clear),
        .payload(word_in),
        .full   (word_full)
    );

    // the serializer only moves while a read word is in flight, when ready is high
    word_serializer i_word_serializer (
        .clk    (clk),
        .rstN   (rstN),
        .load   (ser_load),
        .word   (ser_word),
        .advance(valid),
        .rd_bit (rd),
        .done   (ser_done)
    );

    slave_memory #(
        .MEM_DEPTH(MEM_DEPTH)
    ) i_slave_memory (
        .clk(clk),
        .mem(mem_bus.memory)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// clock and power-on reset source for the serial slave testbench, instantiated by the top module
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops at time zero and is released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- testbench/tb_serial_slave.sv
// self-checking testbench for the serial slave, run as the simulation top with the file list
`timescale 1ns/1ps

module tb_serial_slave;

    localparam int PERIOD_NS = 100;
    localparam int SLAVE_ID  = 1;
    localparam int MEM_DEPTH = 256;
    localparam int DW        = serial_bus_pkg::DATA_WIDTH;
    localparam int N_BURSTS  = 4;
    // 2 single words, up to 12 words per burst round, 5 transfers around dropped headers
    localparam int MAX_WORDS = 2 + N_BURSTS * 12 + 5;
    localparam int TIMEOUT_CYCLES =
        MAX_WORDS * (serial_bus_pkg::HEADER_BITS + 4 * DW) + 200;

    logic clk;
    logic rstN;
    logic control;
    logic wd;
    logic valid;
    logic last;
    logic rd;
    logic ready;

    logic [31:0]           lcg_state;
    serial_bus_pkg::word_t ref_mem [MEM_DEPTH];
    serial_bus_pkg::word_t burst_data [8];
    serial_bus_pkg::word_t exp_q [$];

    // read-side checker state
    logic                  reading;
    serial_bus_pkg::word_t rd_word;
    serial_bus_pkg::word_t exp_word;
    int                    rd_bits;
    logic                  held_valid;
    logic                  held_rd;

    tb_clock_gen #(
        .PERIOD_NS(PERIOD_NS)
    ) i_clock_gen (
        .clk (clk),
        .rstN(rstN)
    );

    serial_slave #(
        .SLAVE_ID (SLAVE_ID),
        .MEM_DEPTH(MEM_DEPTH)
    ) i_serial_slave (
        .clk    (clk),
        .rstN   (rstN),
        .control(control),
        .wd     (wd),
        .valid  (valid),
        .last   (last),
        .rd     (rd),
        .ready  (ready)
    );

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // take the upper lcg bits since the low ones repeat too quickly
    function automatic int random_below(input int n);
        return int'(next_random() >> 16) % n;
    endfunction

    function automatic serial_bus_pkg::word_t random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic serial_bus_pkg::header_t make_header(
        input logic [serial_bus_pkg::START_WIDTH-1:0] start, input int id,
        input logic write, input logic burst, input serial_bus_pkg::addr_t addr);
        serial_bus_pkg::header_t hdr;
        hdr.start     = start;
        hdr.target_id = id[serial_bus_pkg::ID_WIDTH-1:0];
        hdr.write     = write;
        hdr.burst     = burst;
        hdr.addr      = addr;
        return hdr;
    endfunction

    // a target only answers to the right start code and its own id
    function automatic logic header_accepted(input serial_bus_pkg::header_t hdr);
        return (hdr.start == serial_bus_pkg::START_CODE) && (hdr.target_id == SLAVE_ID);
    endfunction

    function automatic void model_write(input int a, input serial_bus_pkg::word_t w);
        ref_mem[a % MEM_DEPTH] = w;
    endfunction

    function automatic serial_bus_pkg::word_t expected_word(input int a);
        return ref_mem[a % MEM_DEPTH];
    endfunction

    task automatic send_header(input serial_bus_pkg::header_t hdr);
        logic [serial_bus_pkg::HEADER_BITS-1:0] bits;
        bits = hdr;
        for (int i = serial_bus_pkg::HEADER_BITS - 1; i >= 0; i--) begin
            @(negedge clk);
            control = bits[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    // moves n words bit by bit where a bit counts only when valid meets ready
    task automatic run_data_phase(input int n_words, input logic burst, input logic is_write);
        int   total;
        int   pos;
        logic v;
        total = n_words * DW;
        pos   = 0;
        while (pos < total) begin
            if (ready) begin
                v     = (random_below(4) != 0);
                valid = v;
                wd    = is_write ? burst_data[pos / DW][DW - 1 - pos % DW] : 1'b0;
                last  = v && burst && (pos == total - 1);
                if (v) begin
                    pos++;
                end
            end else begin
                valid = 1'b0;
                last  = 1'b0;
            end
            @(negedge clk);
        end
        valid = 1'b0;
        last  = 1'b0;
        wd    = 1'b0;
    endtask

    task automatic wait_for_idle();
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    task automatic write_transfer(input logic [serial_bus_pkg::START_WIDTH-1:0] start,
                                  input int id, input serial_bus_pkg::addr_t addr,
                                  input int n_words);
        serial_bus_pkg::header_t hdr;
        hdr = make_header(start, id, 1'b1, n_words > 1, addr);
        send_header(hdr);
        if (header_accepted(hdr)) begin
            run_data_phase(n_words, n_words > 1, 1'b1);
            for (int k = 0; k < n_words; k++) begin
                model_write(int'(addr) + k, burst_data[k]);
            end
        end
        wait_for_idle();
    endtask

    task automatic read_transfer(input serial_bus_pkg::addr_t addr, input int n_words);
        for (int k = 0; k < n_words; k++) begin
            exp_q.push_back(expected_word(int'(addr) + k));
        end
        send_header(make_header(serial_bus_pkg::START_CODE, SLAVE_ID, 1'b0,
                                n_words > 1, addr));
        reading = 1'b1;
        run_data_phase(n_words, n_words > 1, 1'b0);
        reading = 1'b0;
        wait_for_idle();
    endtask

    // assembles rd into words and checks that rd holds through a stall
    always @(posedge clk) begin
        if (reading && ready) begin
            if (held_valid) begin
                check_value("rd", rd, held_rd);
            end
            held_valid = !valid;
            held_rd    = rd;
            if (valid) begin
                rd_word = {rd_word[DW-2:0], rd};
                rd_bits++;
                if (rd_bits == DW) begin
                    rd_bits  = 0;
                    exp_word = exp_q.pop_front();
                    check_value("read word", rd_word, exp_word);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * PERIOD_NS);
        $display("timeout: the transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

    initial begin
        serial_bus_pkg::addr_t a;
        int                    n;
        lcg_state  = 32'd84;
        control    = 1'b0;
        wd         = 1'b0;
        valid      = 1'b0;
        last       = 1'b0;
        reading    = 1'b0;
        rd_word    = '0;
        rd_bits    = 0;
        held_valid = 1'b0;
        held_rd    = 1'b0;
        @(posedge rstN);

        check_value("ready", ready, 32'd1);
        check_value("rd", rd, 32'd0);

        // single word write and read back
        a = serial_bus_pkg::addr_t'(random_below(MEM_DEPTH));
        burst_data[0] = random_word();
        write_transfer(serial_bus_pkg::START_CODE, SLAVE_ID, a, 1);
        read_transfer(a, 1);

        // the first burst runs past the top address
        for (int r = 0; r < N_BURSTS; r++) begin
            if (r == 0) begin
                a = serial_bus_pkg::addr_t'(MEM_DEPTH - 3);
                n = 5;
            end else begin
                a = serial_bus_pkg::addr_t'(random_below(MEM_DEPTH));
                n = 2 + random_below(5);
            end
            for (int k = 0; k < n; k++) begin
                burst_data[k] = random_word();
            end
            write_transfer(serial_bus_pkg::START_CODE, SLAVE_ID, a, n);
            read_transfer(a, n);
        end

        // headers for another target or with a broken start code change nothing
        a = serial_bus_pkg::addr_t'(random_below(MEM_DEPTH));
        burst_data[0] = random_word();
        write_transfer(serial_bus_pkg::START_CODE, SLAVE_ID, a, 1);
        burst_data[0] = random_word();
        write_transfer(serial_bus_pkg::START_CODE, 2, a, 1);
        read_transfer(a, 1);
        burst_data[0] = random_word();
        // 110 still opens with a 1, so the target does see a header
        write_transfer(serial_bus_pkg::START_CODE ^ 3'b001, SLAVE_ID, a, 1);
        read_transfer(a, 1);

        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- serial_slave.f
source/serial_bus_pkg.sv
source/mem_port_if.sv
source/serial_deserializer.sv
source/word_serializer.sv
source/slave_memory.sv
source/transfer_controller.sv
source/serial_slave.sv
testbench/tb_clock_gen.sv
testbench/tb_serial_slave.sv

//--- Bender.yml
package:
  name: serial_slave

dependencies: {}

sources:
  # design, in compile order
  - source/serial_bus_pkg.sv
  - source/mem_port_if.sv
  - source/serial_deserializer.sv
  - source/word_serializer.sv
  - source/slave_memory.sv
  - source/transfer_controller.sv
  - source/serial_slave.sv

  # testbench, top module tb_serial_slave
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_serial_slave.sv
